// File: hw/tx_defines.svh
`ifndef TX_DEFINES_SVH
`define TX_DEFINES_SVH

// Flit geometry.
`define TX_FLIT_BYTES 64
`define TX_DATA_W 512

// Field widths shared by descriptors, metadata and completions.
`define TX_QUEUE_ID_W 6
`define TX_HEAD_W 12
`define TX_LEN_W 20

// Queue depths, in entries.
`define TX_META_DEPTH 32
`define TX_PKT_DEPTH 64
`define TX_PRIO_DEPTH 32
`define TX_CFG_DEPTH 8

// Free entries each queue still has when waitrequest rises.
`define TX_WREQ_ALLOWANCE 4

// Descriptor signal value that marks a configuration descriptor.
`define TX_CFG_SIGNAL 2

`endif

// File: hw/tx_pkg.sv
`include "tx_defines.svh"

package tx_pkg;

  // Transmit descriptor as software writes it to the ring.
  typedef struct packed {
    logic [7:0]                                    signal;
    logic [`TX_LEN_W-1:0]                          length;
    logic [63:0]                                   addr;
    logic [`TX_DATA_W-1-8-`TX_LEN_W-64:0]          pad;
  } tx_dsc_t;

  // One mover write carries either a descriptor or a raw flit.
  typedef union packed {
    tx_dsc_t                 dsc;
    logic [`TX_DATA_W-1:0]   flit;
  } rddm_write_t;

  // Destination address of a mover write. The queue and ring slot ride in
  // the address bits above the 64-byte alignment.
  typedef struct packed {
    logic [63-1-`TX_HEAD_W-`TX_QUEUE_ID_W-6:0] pad;
    logic                                      descriptor;
    logic [`TX_HEAD_W-1:0]                     head;
    logic [`TX_QUEUE_ID_W-1:0]                 queue_id;
    logic [5:0]                                align;
  } rddm_dst_addr_t;

  // Read request for the mover's priority queue.
  typedef struct packed {
    logic [63:0]            src_addr;
    rddm_dst_addr_t         dst_addr;
    logic [`TX_LEN_W-2:0]   nb_dwords;
    logic [7:0]             descriptor_id;
    logic                   single_dst;
  } rddm_desc_t;

  typedef struct packed {
    logic [`TX_QUEUE_ID_W-1:0] queue_id;
    logic [`TX_HEAD_W-1:0]     head;
    logic [`TX_LEN_W-1:0]      total_bytes;
    logic [63:0]               transfer_addr;
    logic                      config_only;
  } tx_meta_t;

  typedef struct packed {
    logic [`TX_QUEUE_ID_W-1:0] queue_id;
    logic [`TX_HEAD_W-1:0]     head;
    logic [63:0]               transfer_addr;
    logic [`TX_LEN_W-1:0]      length;
  } tx_compl_t;

  typedef struct packed {
    logic [`TX_DATA_W-1:0] data;
    logic                  sop;
    logic                  eop;
    logic [5:0]            empty;
  } tx_flit_t;

endpackage

// File: hw/tx_sync_fifo.sv
`timescale 1ns/100ps

module tx_sync_fifo #(
  parameter int  DEPTH  = 16,
  parameter type data_t = logic [7:0]
) (
  input  logic                       clk,
  input  logic                       rst,
  input  data_t                      in_data,
  input  logic                       in_valid,
  output logic                       in_ready,
  output data_t                      out_data,
  output logic                       out_valid,
  input  logic                       out_ready,
  output logic [$clog2(DEPTH+1)-1:0] occupancy
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL = CNT_W'(DEPTH);

  data_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             push;
  logic             pop;

  assign in_ready  = occupancy != FULL;
  assign out_valid = occupancy != '0;
  assign out_data  = mem[rd_ptr];
  assign push      = in_valid & in_ready;
  assign pop       = out_valid & out_ready;

  // Storage is written in place and has no reset.
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      occupancy <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   occupancy <= occupancy + 1'b1;
        2'b01:   occupancy <= occupancy - 1'b1;
        default: occupancy <= occupancy;
      endcase
    end
  end

endmodule

// File: hw/rddm_write_decoder.sv
`timescale 1ns/100ps
`include "tx_defines.svh"

module rddm_write_decoder import tx_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`TX_HEAD_W:0]   rb_size,
  input  logic                  rddm_write,
  input  rddm_dst_addr_t        rddm_address,
  input  rddm_write_t           rddm_writedata,
  input  logic                  waitrequest,
  output rddm_desc_t            prio_data,
  output logic                  prio_valid,
  output tx_meta_t              meta_data,
  output logic                  meta_valid,
  output logic [`TX_DATA_W-1:0] flit_data,
  output logic                  flit_valid,
  output tx_dsc_t               cfg_data,
  output logic                  cfg_valid,
  output logic [31:0]           dsc_cnt,
  output logic [31:0]           pkt_cnt
);

  logic                      accept;
  logic                      is_dsc;
  logic                      is_cfg;
  tx_dsc_t                   dsc;
  logic [`TX_HEAD_W-1:0]     head_mask;
  logic [`TX_QUEUE_ID_W-1:0] last_qid;
  logic                      last_qid_invalid;
  logic [`TX_HEAD_W-1:0]     last_head;
  logic [`TX_HEAD_W-1:0]     cur_head;
  logic [`TX_LEN_W:0]        len_round;
  rddm_dst_addr_t            pkt_dst;
  rddm_desc_t                req;
  tx_meta_t                  meta;

  assign accept = rddm_write & ~waitrequest;
  assign is_dsc = rddm_address.descriptor;
  assign dsc    = rddm_writedata.dsc;
  assign is_cfg = dsc.signal == `TX_CFG_SIGNAL;

  // rb_size is a power of two, so the mask is simply one below it.
  assign head_mask = rb_size[`TX_HEAD_W-1:0] - 1'b1;

  // Descriptors of one queue arrive back to back, so only the first one
  // after a queue change takes its head from the address.
  assign cur_head = (!last_qid_invalid && rddm_address.queue_id == last_qid) ?
                    ((last_head + 1'b1) & head_mask) : rddm_address.head;

  always_comb begin
    pkt_dst            = rddm_address;
    pkt_dst.descriptor = 1'b0;
    pkt_dst.head       = cur_head;

    len_round = {1'b0, dsc.length} + 2'd3;

    req.src_addr      = dsc.addr;
    req.dst_addr      = pkt_dst;
    req.nb_dwords     = len_round[`TX_LEN_W:2];
    req.descriptor_id = 8'd1;
    req.single_dst    = 1'b1;

    meta.queue_id      = rddm_address.queue_id;
    meta.head          = cur_head;
    meta.total_bytes   = dsc.length;
    meta.transfer_addr = dsc.addr;
    meta.config_only   = is_cfg;
  end

  //////////////////////////////////////////////////////////////////////
  // Queue pushes and head tracking
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      prio_valid       <= 1'b0;
      meta_valid       <= 1'b0;
      flit_valid       <= 1'b0;
      cfg_valid        <= 1'b0;
      last_qid_invalid <= 1'b1;
      dsc_cnt          <= '0;
      pkt_cnt          <= '0;
    end else begin
      prio_valid <= accept & is_dsc & ~is_cfg;
      meta_valid <= accept & is_dsc;
      cfg_valid  <= accept & is_dsc & is_cfg;
      flit_valid <= accept & ~is_dsc;
      if (accept & is_dsc) begin
        last_qid_invalid <= 1'b0;
        dsc_cnt          <= dsc_cnt + 1'b1;
      end
      if (accept & ~is_dsc) begin
        pkt_cnt <= pkt_cnt + 1'b1;
      end
    end
  end

  // The payload registers load every cycle. Only the valids above matter.
  always_ff @(posedge clk) begin
    prio_data <= req;
    meta_data <= meta;
    cfg_data  <= dsc;
    flit_data <= rddm_writedata.flit;
    if (accept & is_dsc) begin
      last_qid  <= rddm_address.queue_id;
      last_head <= cur_head;
    end
  end

endmodule

// File: hw/tx_packet_streamer.sv
`timescale 1ns/100ps
`include "tx_defines.svh"

module tx_packet_streamer import tx_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  tx_meta_t              meta_data,
  input  logic                  meta_valid,
  output logic                  meta_ready,
  input  logic [`TX_DATA_W-1:0] flit_data,
  input  logic                  flit_valid,
  output logic                  flit_ready,
  output tx_flit_t              out_pkt,
  output logic                  out_pkt_valid,
  input  logic                  out_pkt_ready,
  output tx_compl_t             compl,
  output logic                  compl_valid,
  input  logic                  compl_ready,
  output logic [31:0]           batch_cnt
);

  localparam logic [`TX_LEN_W-1:0] FLIT_BYTES = `TX_FLIT_BYTES;

  tx_meta_t             cur_meta;
  logic                 batch_open;
  logic [`TX_LEN_W-1:0] batch_left;
  logic [`TX_LEN_W-1:0] pkt_left;
  logic                 next_sop;
  logic                 pkt_slot;
  logic                 compl_slot;
  logic                 meta_no_data;
  logic                 last_flit;
  logic [`TX_LEN_W-1:0] first_len;
  logic [`TX_LEN_W-1:0] cur_pkt_left;
  logic                 flit_eop;
  logic                 meta_pop;
  logic                 flit_pop;

  function automatic tx_compl_t to_compl(tx_meta_t m);
    tx_compl_t c;
    c.queue_id      = m.queue_id;
    c.head          = m.head;
    c.transfer_addr = m.transfer_addr;
    c.length        = m.total_bytes;
    return c;
  endfunction

  // An output register can take a new result when empty or draining now.
  assign pkt_slot   = ~out_pkt_valid | out_pkt_ready;
  assign compl_slot = ~compl_valid | compl_ready;

  assign meta_no_data = meta_data.config_only | (meta_data.total_bytes == '0);
  assign last_flit    = batch_left <= FLIT_BYTES;

  // The last flit of a batch also produces the completion, so it waits for
  // room in both registers.
  assign meta_ready = ~batch_open & (~meta_no_data | compl_slot);
  assign flit_ready = batch_open & pkt_slot & (~last_flit | compl_slot);
  assign meta_pop   = meta_valid & meta_ready;
  assign flit_pop   = flit_valid & flit_ready;

  // Packet length sits in bytes 16 and 17 of the first flit, network order.
  assign first_len    = {{(`TX_LEN_W-16){1'b0}}, flit_data[135:128], flit_data[143:136]};
  assign cur_pkt_left = next_sop ? first_len : pkt_left;
  assign flit_eop     = cur_pkt_left <= FLIT_BYTES;

  //////////////////////////////////////////////////////////////////////
  // Batch and packet state
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      batch_open    <= 1'b0;
      next_sop      <= 1'b1;
      batch_left    <= '0;
      pkt_left      <= '0;
      out_pkt_valid <= 1'b0;
      compl_valid   <= 1'b0;
      batch_cnt     <= '0;
    end else begin
      if (out_pkt_ready) begin
        out_pkt_valid <= 1'b0;
      end
      if (compl_ready) begin
        compl_valid <= 1'b0;
      end

      if (meta_pop) begin
        next_sop   <= 1'b1;
        batch_left <= meta_data.total_bytes;
        if (meta_no_data) begin
          compl_valid <= 1'b1;
          batch_cnt   <= batch_cnt + 1'b1;
        end else begin
          batch_open <= 1'b1;
        end
      end

      if (flit_pop) begin
        out_pkt_valid <= 1'b1;
        next_sop      <= flit_eop;
        pkt_left      <= cur_pkt_left - FLIT_BYTES;
        batch_left    <= batch_left - FLIT_BYTES;
        if (last_flit) begin
          batch_open  <= 1'b0;
          compl_valid <= 1'b1;
          batch_cnt   <= batch_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (meta_pop) begin
      cur_meta <= meta_data;
    end
    if (flit_pop) begin
      out_pkt.data  <= flit_data;
      out_pkt.sop   <= next_sop;
      out_pkt.eop   <= flit_eop;
      out_pkt.empty <= '0;
    end
    if (meta_pop & meta_no_data) begin
      compl <= to_compl(meta_data);
    end else if (flit_pop & last_flit) begin
      compl <= to_compl(cur_meta);
    end
  end

endmodule

// File: hw/cpu_to_fpga_tx.sv
`timescale 1ns/100ps
`include "tx_defines.svh"

module cpu_to_fpga_tx import tx_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic [`TX_HEAD_W:0] rb_size,
  input  logic                rddm_write,
  input  rddm_dst_addr_t      rddm_address,
  input  rddm_write_t         rddm_writedata,
  output logic                waitrequest,
  output rddm_desc_t          rddm_prio_data,
  output logic                rddm_prio_valid,
  input  logic                rddm_prio_ready,
  output tx_dsc_t             cfg_data,
  output logic                cfg_valid,
  input  logic                cfg_ready,
  output tx_flit_t            out_pkt,
  output logic                out_pkt_valid,
  input  logic                out_pkt_ready,
  output tx_compl_t           compl,
  output logic                compl_valid,
  input  logic                compl_ready,
  output logic [31:0]         dsc_cnt,
  output logic [31:0]         pkt_cnt,
  output logic [31:0]         batch_cnt
);

  localparam int PRIO_W = $clog2(`TX_PRIO_DEPTH + 1);
  localparam int META_W = $clog2(`TX_META_DEPTH + 1);
  localparam int PKT_W  = $clog2(`TX_PKT_DEPTH + 1);
  localparam int CFG_W  = $clog2(`TX_CFG_DEPTH + 1);

  localparam logic [PRIO_W-1:0] PRIO_LIMIT = PRIO_W'(`TX_PRIO_DEPTH - `TX_WREQ_ALLOWANCE);
  localparam logic [META_W-1:0] META_LIMIT = META_W'(`TX_META_DEPTH - `TX_WREQ_ALLOWANCE);
  localparam logic [PKT_W-1:0]  PKT_LIMIT  = PKT_W'(`TX_PKT_DEPTH - `TX_WREQ_ALLOWANCE);
  localparam logic [CFG_W-1:0]  CFG_LIMIT  = CFG_W'(`TX_CFG_DEPTH - `TX_WREQ_ALLOWANCE);

  rddm_desc_t            prio_in_data;
  logic                  prio_in_valid;
  logic [PRIO_W-1:0]     prio_occ;
  tx_meta_t              meta_in_data;
  logic                  meta_in_valid;
  tx_meta_t              meta_out_data;
  logic                  meta_out_valid;
  logic                  meta_out_ready;
  logic [META_W-1:0]     meta_occ;
  logic [`TX_DATA_W-1:0] pkt_in_data;
  logic                  pkt_in_valid;
  logic [`TX_DATA_W-1:0] pkt_out_data;
  logic                  pkt_out_valid;
  logic                  pkt_out_ready;
  logic [PKT_W-1:0]      pkt_occ;
  tx_dsc_t               cfg_in_data;
  logic                  cfg_in_valid;
  logic [CFG_W-1:0]      cfg_occ;

  // Every queue is covered, so a write can always land in its queue. The
  // allowance absorbs the write already held in the decoder register.
  assign waitrequest = (prio_occ >= PRIO_LIMIT) | (meta_occ >= META_LIMIT) |
                       (pkt_occ >= PKT_LIMIT) | (cfg_occ >= CFG_LIMIT);

  rddm_write_decoder u_decoder (
    .clk            (clk),
    .rst            (rst),
    .rb_size        (rb_size),
    .rddm_write     (rddm_write),
    .rddm_address   (rddm_address),
    .rddm_writedata (rddm_writedata),
    .waitrequest    (waitrequest),
    .prio_data      (prio_in_data),
    .prio_valid     (prio_in_valid),
    .meta_data      (meta_in_data),
    .meta_valid     (meta_in_valid),
    .flit_data      (pkt_in_data),
    .flit_valid     (pkt_in_valid),
    .cfg_data       (cfg_in_data),
    .cfg_valid      (cfg_in_valid),
    .dsc_cnt        (dsc_cnt),
    .pkt_cnt        (pkt_cnt)
  );

  //////////////////////////////////////////////////////////////////////
  // Queues
  //////////////////////////////////////////////////////////////////////

  tx_sync_fifo #(.DEPTH(`TX_PRIO_DEPTH), .data_t(rddm_desc_t)) prio_queue (
    .clk       (clk),
    .rst       (rst),
    .in_data   (prio_in_data),
    .in_valid  (prio_in_valid),
    .in_ready  (),
    .out_data  (rddm_prio_data),
    .out_valid (rddm_prio_valid),
    .out_ready (rddm_prio_ready),
    .occupancy (prio_occ)
  );

  tx_sync_fifo #(.DEPTH(`TX_META_DEPTH), .data_t(tx_meta_t)) meta_queue (
    .clk       (clk),
    .rst       (rst),
    .in_data   (meta_in_data),
    .in_valid  (meta_in_valid),
    .in_ready  (),
    .out_data  (meta_out_data),
    .out_valid (meta_out_valid),
    .out_ready (meta_out_ready),
    .occupancy (meta_occ)
  );

  tx_sync_fifo #(.DEPTH(`TX_PKT_DEPTH), .data_t(logic [`TX_DATA_W-1:0])) pkt_queue (
    .clk       (clk),
    .rst       (rst),
    .in_data   (pkt_in_data),
    .in_valid  (pkt_in_valid),
    .in_ready  (),
    .out_data  (pkt_out_data),
    .out_valid (pkt_out_valid),
    .out_ready (pkt_out_ready),
    .occupancy (pkt_occ)
  );

  tx_sync_fifo #(.DEPTH(`TX_CFG_DEPTH), .data_t(tx_dsc_t)) cfg_queue (
    .clk       (clk),
    .rst       (rst),
    .in_data   (cfg_in_data),
    .in_valid  (cfg_in_valid),
    .in_ready  (),
    .out_data  (cfg_data),
    .out_valid (cfg_valid),
    .out_ready (cfg_ready),
    .occupancy (cfg_occ)
  );

  tx_packet_streamer u_streamer (
    .clk           (clk),
    .rst           (rst),
    .meta_data     (meta_out_data),
    .meta_valid    (meta_out_valid),
    .meta_ready    (meta_out_ready),
    .flit_data     (pkt_out_data),
    .flit_valid    (pkt_out_valid),
    .flit_ready    (pkt_out_ready),
    .out_pkt       (out_pkt),
    .out_pkt_valid (out_pkt_valid),
    .out_pkt_ready (out_pkt_ready),
    .compl         (compl),
    .compl_valid   (compl_valid),
    .compl_ready   (compl_ready),
    .batch_cnt     (batch_cnt)
  );

endmodule

// File: verification/tb_cpu_to_fpga_tx.sv
`timescale 1ns/100ps
`include "tx_defines.svh"

module tb_cpu_to_fpga_tx import tx_pkg::*; ();

  localparam int CLK_PERIOD = 40;
  localparam int NB_BATCHES = 60;
  localparam int RB_SIZE    = 256;
  localparam int SEED       = 46407;

  logic                clk = 1'b0;
  logic                rst;
  logic [`TX_HEAD_W:0] rb_size;
  logic                rddm_write;
  rddm_dst_addr_t      rddm_address;
  rddm_write_t         rddm_writedata;
  logic                waitrequest;
  rddm_desc_t          rddm_prio_data;
  logic                rddm_prio_valid;
  logic                rddm_prio_ready;
  tx_dsc_t             cfg_data;
  logic                cfg_valid;
  logic                cfg_ready;
  tx_flit_t            out_pkt;
  logic                out_pkt_valid;
  logic                out_pkt_ready;
  tx_compl_t           compl;
  logic                compl_valid;
  logic                compl_ready;
  logic [31:0]         dsc_cnt;
  logic [31:0]         pkt_cnt;
  logic [31:0]         batch_cnt;

  // Writes to issue, and the results the DUT owes for them.
  rddm_dst_addr_t wr_addr_q[$];
  rddm_write_t    wr_data_q[$];
  rddm_desc_t     exp_prio_q[$];
  tx_dsc_t        exp_cfg_q[$];
  tx_flit_t       exp_flit_q[$];
  tx_compl_t      exp_compl_q[$];
  int             n_writes;
  int             n_flits;
  bit             stim_ready = 1'b0;

  // Back-pressure phase, and whether the queues ever filled up.
  int             bp_cycle = 0;
  bit             stall;
  bit             saw_wreq = 1'b0;

  // Head tracking state of the reference model.
  bit                        have_last = 1'b0;
  logic [`TX_QUEUE_ID_W-1:0] last_qid;
  logic [`TX_HEAD_W-1:0]     last_head;

  cpu_to_fpga_tx u_dut (
    .clk             (clk),
    .rst             (rst),
    .rb_size         (rb_size),
    .rddm_write      (rddm_write),
    .rddm_address    (rddm_address),
    .rddm_writedata  (rddm_writedata),
    .waitrequest     (waitrequest),
    .rddm_prio_data  (rddm_prio_data),
    .rddm_prio_valid (rddm_prio_valid),
    .rddm_prio_ready (rddm_prio_ready),
    .cfg_data        (cfg_data),
    .cfg_valid       (cfg_valid),
    .cfg_ready       (cfg_ready),
    .out_pkt         (out_pkt),
    .out_pkt_valid   (out_pkt_valid),
    .out_pkt_ready   (out_pkt_ready),
    .compl           (compl),
    .compl_valid     (compl_valid),
    .compl_ready     (compl_ready),
    .dsc_cnt         (dsc_cnt),
    .pkt_cnt         (pkt_cnt),
    .batch_cnt       (batch_cnt)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Failure reporting and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(string reason);
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1, "Simulation stopped on the first error.");
  endtask

  task automatic check_prio(rddm_desc_t got, rddm_desc_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR %0t rddm_prio_data got %h expected %h", $time, got, exp));
    end
  endtask

  task automatic check_cfg(tx_dsc_t got, tx_dsc_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR %0t cfg_data got %h expected %h", $time, got, exp));
    end
  endtask

  task automatic check_flit(tx_flit_t got, tx_flit_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR %0t out_pkt got %h expected %h", $time, got, exp));
    end
  endtask

  task automatic check_compl(tx_compl_t got, tx_compl_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR %0t compl got %h expected %h", $time, got, exp));
    end
  endtask

  task automatic check_count(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR %0t %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus generation and reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [`TX_DATA_W-1:0] random_word();
    logic [`TX_DATA_W-1:0] w;
    for (int i = 0; i < `TX_DATA_W / 32; i++) begin
      w[i*32 +: 32] = $urandom;
    end
    return w;
  endfunction

  // A descriptor of the same queue as the one before it takes the next slot
  // of the ring; any other takes the head carried in its address.
  function automatic logic [`TX_HEAD_W-1:0] next_head(logic [`TX_QUEUE_ID_W-1:0] qid,
                                                      logic [`TX_HEAD_W-1:0] addr_head);
    logic [`TX_HEAD_W-1:0] head;
    if (have_last && qid == last_qid) begin
      head = `TX_HEAD_W'((last_head + 1) & (RB_SIZE - 1));
    end else begin
      head = addr_head;
    end
    have_last = 1'b1;
    last_qid  = qid;
    last_head = head;
    return head;
  endfunction

  task automatic add_packet(logic [`TX_QUEUE_ID_W-1:0] qid, int len);
    rddm_dst_addr_t a;
    rddm_write_t    w;
    tx_flit_t       f;
    int             left;
    left  = len;
    f.sop = 1'b1;
    while (left > 0) begin
      a            = rddm_dst_addr_t'({$urandom, $urandom});
      a.descriptor = 1'b0;
      a.queue_id   = qid;
      w.flit       = random_word();
      if (f.sop) begin
        // Length in network order, bytes 16 and 17.
        w.flit[16*8 +: 8] = len[15:8];
        w.flit[17*8 +: 8] = len[7:0];
      end
      f.data  = w.flit;
      f.eop   = left <= `TX_FLIT_BYTES;
      f.empty = '0;
      wr_addr_q.push_back(a);
      wr_data_q.push_back(w);
      exp_flit_q.push_back(f);
      left  -= `TX_FLIT_BYTES;
      f.sop  = 1'b0;
    end
  endtask

  task automatic add_batch();
    rddm_dst_addr_t        a;
    rddm_write_t           w;
    tx_dsc_t               d;
    rddm_desc_t            r;
    tx_compl_t             c;
    logic [`TX_HEAD_W-1:0] head;
    int                    pkt_len[$];
    int                    total;
    int                    npkt;
    a            = rddm_dst_addr_t'({$urandom, $urandom});
    a.descriptor = 1'b1;
    if (have_last && ($urandom % 2 == 0)) begin
      a.queue_id = last_qid;
    end else begin
      a.queue_id = `TX_QUEUE_ID_W'($urandom % 4);
    end
    // Heads near the top of the ring make wrap-around frequent.
    a.head = ($urandom % 2 == 0) ? `TX_HEAD_W'(248 + $urandom % 8) :
                                   `TX_HEAD_W'($urandom % RB_SIZE);
    head   = next_head(a.queue_id, a.head);
    d      = tx_dsc_t'(random_word());
    d.addr = {$urandom, $urandom};
    if ($urandom % 4 == 0) begin
      d.signal = `TX_CFG_SIGNAL;
      d.length = `TX_LEN_W'($urandom % 2048);
      exp_cfg_q.push_back(d);
    end else begin
      // Only the last packet of a batch may end inside a flit.
      npkt  = 1 + $urandom % 3;
      total = 0;
      for (int i = 0; i < npkt; i++) begin
        pkt_len.push_back(i < npkt - 1 ? 64 * (1 + $urandom % 3) : 18 + $urandom % 180);
        total += pkt_len[i];
      end
      d.signal              = 8'($urandom % 2);
      d.length              = `TX_LEN_W'(total);
      r.src_addr            = d.addr;
      r.dst_addr            = a;
      r.dst_addr.descriptor = 1'b0;
      r.dst_addr.head       = head;
      r.nb_dwords           = (`TX_LEN_W-1)'((total + 3) / 4);
      r.descriptor_id       = 8'd1;
      r.single_dst          = 1'b1;
      exp_prio_q.push_back(r);
    end
    w.dsc = d;
    wr_addr_q.push_back(a);
    wr_data_q.push_back(w);
    c.queue_id      = a.queue_id;
    c.head          = head;
    c.transfer_addr = d.addr;
    c.length        = d.length;
    exp_compl_q.push_back(c);
    foreach (pkt_len[i]) begin
      add_packet(a.queue_id, pkt_len[i]);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Processes
  //////////////////////////////////////////////////////////////////////

  initial begin
    int idx;
    void'($urandom(SEED));
    rst             = 1'b1;
    rb_size         = RB_SIZE;
    rddm_write      = 1'b0;
    rddm_address    = '0;
    rddm_writedata  = '0;
    rddm_prio_ready = 1'b0;
    cfg_ready       = 1'b0;
    out_pkt_ready   = 1'b0;
    compl_ready     = 1'b0;
    for (int b = 0; b < NB_BATCHES; b++) begin
      add_batch();
    end
    n_writes   = wr_addr_q.size();
    n_flits    = exp_flit_q.size();
    stim_ready = 1'b1;

    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    if (rddm_prio_valid || cfg_valid || out_pkt_valid || compl_valid || waitrequest) begin
      abort_run("An output valid or waitrequest is high right after reset.");
    end
    check_count("dsc_cnt", dsc_cnt, 0);
    check_count("pkt_cnt", pkt_cnt, 0);
    check_count("batch_cnt", batch_cnt, 0);

    // A write is only raised while waitrequest is low, and then it is taken
    // at the next edge.
    idx = 0;
    while (idx < n_writes) begin
      @(posedge clk);
      #2;
      if (!waitrequest && ($urandom % 4 != 0)) begin
        rddm_write     = 1'b1;
        rddm_address   = wr_addr_q[idx];
        rddm_writedata = wr_data_q[idx];
        idx++;
      end else begin
        rddm_write = 1'b0;
      end
    end
    @(posedge clk);
    #2;
    rddm_write = 1'b0;

    while (exp_prio_q.size() + exp_cfg_q.size() + exp_flit_q.size() +
           exp_compl_q.size() > 0) begin
      @(posedge clk);
      #1;
    end
    repeat (10) @(posedge clk);
    #2;
    check_count("dsc_cnt", dsc_cnt, NB_BATCHES);
    check_count("pkt_cnt", pkt_cnt, n_flits);
    check_count("batch_cnt", batch_cnt, NB_BATCHES);
    if (!saw_wreq) begin
      abort_run("waitrequest never rose although every output was stalled.");
    end else if (rddm_prio_valid || cfg_valid || out_pkt_valid || compl_valid ||
                 waitrequest) begin
      abort_run("An output valid or waitrequest is still high after the run drained.");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

  // Random back-pressure on every output. Long stalls now and then let the
  // queues fill far enough to raise waitrequest.
  always begin
    @(posedge clk);
    #2;
    bp_cycle++;
    stall           = (bp_cycle % 400) < 150;
    rddm_prio_ready = !stall && (($urandom % 4) != 0);
    cfg_ready       = !stall && (($urandom % 4) != 0);
    out_pkt_ready   = !stall && (($urandom % 4) != 0);
    compl_ready     = !stall && (($urandom % 4) != 0);
  end

  always @(posedge clk) begin
    if (!rst) begin
      if (waitrequest) begin
        saw_wreq = 1'b1;
      end
      if (rddm_prio_valid && rddm_prio_ready) begin
        if (exp_prio_q.size() == 0) begin
          abort_run("A read request came out when none was expected.");
        end else begin
          check_prio(rddm_prio_data, exp_prio_q.pop_front());
        end
      end
      if (cfg_valid && cfg_ready) begin
        if (exp_cfg_q.size() == 0) begin
          abort_run("A configuration entry came out when none was expected.");
        end else begin
          check_cfg(cfg_data, exp_cfg_q.pop_front());
        end
      end
      if (out_pkt_valid && out_pkt_ready) begin
        if (exp_flit_q.size() == 0) begin
          abort_run("A packet flit came out when none was expected.");
        end else begin
          check_flit(out_pkt, exp_flit_q.pop_front());
        end
      end
      if (compl_valid && compl_ready) begin
        if (exp_compl_q.size() == 0) begin
          abort_run("A completion came out when none was expected.");
        end else begin
          check_compl(compl, exp_compl_q.pop_front());
        end
      end
    end
  end

  // Allows 200 cycles for every write issued, plus room for reset and drain.
  initial begin
    wait (stim_ready);
    #(CLK_PERIOD * (200 * n_writes + 1000));
    abort_run("Timeout: the DUT did not deliver every expected result in time.");
  end

endmodule

// File: flist.f
+incdir+hw
hw/tx_pkg.sv
hw/tx_sync_fifo.sv
hw/rddm_write_decoder.sv
hw/tx_packet_streamer.sv
hw/cpu_to_fpga_tx.sv
verification/tb_cpu_to_fpga_tx.sv

// File: Bender.yml
package:
  name: cpu_to_fpga_tx

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/tx_pkg.sv
      - hw/tx_sync_fifo.sv
      - hw/rddm_write_decoder.sv
      - hw/tx_packet_streamer.sv
      - hw/cpu_to_fpga_tx.sv
      - target: test
        include_dirs:
          - hw
        files:
          - verification/tb_cpu_to_fpga_tx.sv
